// ==== source/uart_pkg.sv ====
/*
 * mini uart shared definitions
 * register map, status bit positions, reset divisors, oversampling ratio
 */

package uart_pkg;

    //////////////////////////////////////////////////
    // register word offsets, address bits 4..2
    //////////////////////////////////////////////////
    localparam logic [2:0] off_data = 3'd0;   // tx byte on write, rx byte on read
    localparam logic [2:0] off_lsr  = 3'd1;   // line status, read only
    localparam logic [2:0] off_divr = 3'd2;   // rx sample divisor
    localparam logic [2:0] off_divt = 3'd3;   // tx bit divisor

    //////////////////////////////////////////////////
    // line status
    //////////////////////////////////////////////////
    localparam int lsr_rx_ready_bit = 0;      // received byte waiting
    localparam int lsr_tx_ready_bit = 5;      // transmitter idle

    typedef logic [5:0] lsr_t;

    // data byte carried on the serial line
    typedef logic [7:0] byte_t;

    //////////////////////////////////////////////////
    // baud
    //////////////////////////////////////////////////
    // samples per bit on the receive side
    localparam int rx_os = 16;

    // 9600 baud from a 25 MHz clock
    localparam logic [15:0] baud_snd_reset = 16'd2604;  // 25e6 / 9600
    localparam logic [15:0] baud_rcv_reset = 16'd163;   // 25e6 / (9600 * 16)

endpackage

// ==== source/uart_ctl_if.sv ====
/*
 * control links between the register block and the serial units
 * tx byte and load, rx byte and clear, both baud divisors
 */

interface uart_ctl_if #(
    parameter int DIV_W = 16
);

    // transmit side
    uart_pkg::byte_t  tx_data;    // byte to send
    logic             tx_load;    // one cycle, start a frame
    logic             tx_ready;   // level, transmitter idle

    // receive side
    uart_pkg::byte_t  rx_data;    // last good byte
    logic             rx_ready;   // level, byte not yet read
    logic             rx_clear;   // data read strobe

    // divisors
    logic [DIV_W-1:0] div_rx;     // clocks per rx sample
    logic [DIV_W-1:0] div_tx;     // clocks per tx bit

    modport regs (
        output tx_data, tx_load, rx_clear, div_rx, div_tx,
        input  tx_ready, rx_data, rx_ready
    );

    modport tx (
        input  tx_data, tx_load,
        output tx_ready
    );

    modport rx (
        output rx_data, rx_ready,
        input  rx_clear
    );

    modport baud (input div_rx, div_tx);

endinterface

// ==== source/uart_regs.sv ====
/*
 * uart register block
 * zero-wait bus slave, holds tx byte and divisors, builds line status,
 * issues the tx load pulse and the rx read-clear strobe
 */

module uart_regs #(
    parameter int DIV_W = 16
) (
    input  logic        CLK_I,
    input  logic        RST_I,
    input  logic [2:0]  adr,      // word offset
    input  logic [31:0] dat_w,
    output logic [31:0] dat_r,
    input  logic        stb,
    input  logic        we,
    output logic        ack,
    uart_ctl_if.regs    ctl
);

    logic           wr_en;        // bus write this cycle
    logic           rd_en;        // bus read this cycle
    uart_pkg::lsr_t lsr;

    assign ack   = stb;           // zero wait
    assign wr_en = stb & we;
    assign rd_en = stb & ~we;

    //////////////////////////////////////////////////
    // write side
    //////////////////////////////////////////////////

    // byte for the transmitter
    always_ff @(posedge CLK_I)
    begin
        if (wr_en && adr == uart_pkg::off_data)
            ctl.tx_data <= dat_w[7:0];
    end

    always_ff @(posedge CLK_I or posedge RST_I)
    begin
        if (RST_I)
        begin
            ctl.div_rx <= DIV_W'(uart_pkg::baud_rcv_reset);
            ctl.div_tx <= DIV_W'(uart_pkg::baud_snd_reset);
        end
        else if (wr_en)
        begin
            case (adr)
                uart_pkg::off_divr: ctl.div_rx <= dat_w[DIV_W-1:0];
                uart_pkg::off_divt: ctl.div_tx <= dat_w[DIV_W-1:0];
                default: ;        // data handled above, rest ignored
            endcase
        end
    end

    // load strobe, one cycle behind the data write
    always_ff @(posedge CLK_I or posedge RST_I)
    begin
        if (RST_I)
            ctl.tx_load <= 1'b0;
        else
            ctl.tx_load <= wr_en && adr == uart_pkg::off_data && !ctl.tx_load;
    end

    // reading the byte releases it
    assign ctl.rx_clear = rd_en && adr == uart_pkg::off_data;

    //////////////////////////////////////////////////
    // read side
    //////////////////////////////////////////////////

    always_comb
    begin
        lsr = '0;                                     // unused bits stay low
        lsr[uart_pkg::lsr_tx_ready_bit] = ctl.tx_ready;
        lsr[uart_pkg::lsr_rx_ready_bit] = ctl.rx_ready;
    end

    always_comb
    begin
        case (adr)
            uart_pkg::off_data: dat_r = 32'(ctl.rx_data);
            uart_pkg::off_lsr:  dat_r = 32'(lsr);
            uart_pkg::off_divr: dat_r = 32'(ctl.div_rx);
            uart_pkg::off_divt: dat_r = 32'(ctl.div_tx);
            default:            dat_r = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    // transmitter sees one load per write, never a held level
    a_load_pulse: assert property (@(posedge CLK_I) disable iff (RST_I)
        ctl.tx_load |=> !ctl.tx_load);

endmodule

// ==== source/uart_baud_gen.sv ====
/*
 * baud enable generator
 * two free-running down-counters, tx bit enable and rx sample enable
 */

module uart_baud_gen #(
    parameter int DIV_W = 16
) (
    input  logic     CLK_I,
    input  logic     RST_I,
    uart_ctl_if.baud ctl,
    output logic     en_tx,
    output logic     en_rx
);

    logic [DIV_W-1:0] div [2];    // 0 tx, 1 rx
    logic [1:0]       en;

    assign div[0] = ctl.div_tx;
    assign div[1] = ctl.div_rx;
    assign en_tx  = en[0];
    assign en_rx  = en[1];

    //////////////////////////////////////////////////
    // one counter per channel
    //////////////////////////////////////////////////
    for (genvar i = 0; i < 2; i++)
    begin : g_chan
        logic [DIV_W-1:0] cnt;
        logic [DIV_W-1:0] div_q;  // divisor last loaded
        logic             chg;    // divisor rewritten

        assign chg   = div[i] != div_q;
        assign en[i] = cnt == '0 && !chg;   // no pulse on a reload

        always_ff @(posedge CLK_I or posedge RST_I)
        begin
            if (RST_I)
            begin
                cnt   <= '0;
                div_q <= '0;      // forces a load right after reset
            end
            else if (chg || cnt == '0)
            begin
                cnt   <= div[i] - 1'b1;
                div_q <= div[i];
            end
            else
                cnt <= cnt - 1'b1;
        end

        // zero would wrap the counter to its full range
        a_div_nz: assert property (@(posedge CLK_I) disable iff (RST_I)
            chg |-> div[i] != '0);
    end

endmodule

// ==== source/uart_tx.sv ====
/*
 * uart transmitter
 * start bit, eight data bits lsb first, one stop bit, paced by en_tx
 */

module uart_tx (
    input  logic   CLK_I,
    input  logic   RST_I,
    uart_ctl_if.tx ctl,
    input  logic   en_tx,         // one pulse per bit time
    output logic   txd
);

    typedef enum logic [2:0] {S_IDLE, S_WAIT, S_START, S_DATA, S_STOP} state_t;

    state_t          state;
    logic [2:0]      bit_cnt;     // data bits already out after the first
    uart_pkg::byte_t sh;          // outgoing bits, lsb next

    assign ctl.tx_ready = state == S_IDLE;

    //////////////////////////////////////////////////
    // frame sequencer
    //////////////////////////////////////////////////
    always_ff @(posedge CLK_I or posedge RST_I)
    begin
        if (RST_I)
        begin
            state   <= S_IDLE;
            bit_cnt <= '0;
            txd     <= 1'b1;      // line idles high
        end
        else
        begin
            case (state)
                S_IDLE:
                    if (ctl.tx_load)
                        state <= S_WAIT;    // align to the bit grid
                S_WAIT:
                    if (en_tx)
                    begin
                        state <= S_START;
                        txd   <= 1'b0;
                    end
                S_START:
                    if (en_tx)
                    begin
                        state   <= S_DATA;
                        txd     <= sh[0];
                        bit_cnt <= '0;
                    end
                S_DATA:
                    if (en_tx)
                    begin
                        if (bit_cnt == 3'd7)
                        begin
                            state <= S_STOP;
                            txd   <= 1'b1;
                        end
                        else
                        begin
                            txd     <= sh[0];
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                S_STOP:
                    if (en_tx)
                        state <= S_IDLE;    // stop bit done
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    // capture on load, shift as each bit is driven
    always_ff @(posedge CLK_I)
    begin
        if (state == S_IDLE && ctl.tx_load)
            sh <= ctl.tx_data;
        else if (en_tx && (state == S_START || state == S_DATA))
            sh <= sh >> 1;
    end

    a_idle_high: assert property (@(posedge CLK_I) disable iff (RST_I)
        state == S_IDLE |-> txd);

endmodule

// ==== source/uart_rx.sv ====
/*
 * uart receiver
 * 16x oversampling, start bit checked at half a bit, then mid-bit samples
 */

module uart_rx (
    input  logic   CLK_I,
    input  logic   RST_I,
    uart_ctl_if.rx ctl,
    input  logic   en_rx,         // rx_os pulses per bit
    input  logic   rxd
);

    localparam int              OS_W    = $clog2(uart_pkg::rx_os);
    localparam logic [OS_W-1:0] OS_HALF = OS_W'(uart_pkg::rx_os / 2 - 1);
    localparam logic [OS_W-1:0] OS_LAST = OS_W'(uart_pkg::rx_os - 1);

    typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} state_t;

    state_t          state;
    logic            rxd_s1;      // sync stages
    logic            rxd_s2;
    logic            rxd_q;       // previous synced level
    logic            fall;        // line went low
    logic [OS_W-1:0] os_cnt;      // enables within the bit
    logic [2:0]      bit_cnt;
    logic            sample;      // mid-bit point
    logic            stop_ok;     // good stop bit seen
    uart_pkg::byte_t sh;

    assign fall    = rxd_q & ~rxd_s2;
    assign sample  = en_rx && os_cnt == OS_LAST;
    assign stop_ok = state == S_STOP && sample && rxd_s2;

    //////////////////////////////////////////////////
    // input sync
    //////////////////////////////////////////////////
    always_ff @(posedge CLK_I or posedge RST_I)
    begin
        if (RST_I)
        begin
            rxd_s1 <= 1'b1;
            rxd_s2 <= 1'b1;
            rxd_q  <= 1'b1;
        end
        else
        begin
            rxd_s1 <= rxd;
            rxd_s2 <= rxd_s1;
            rxd_q  <= rxd_s2;
        end
    end

    //////////////////////////////////////////////////
    // frame sequencer
    //////////////////////////////////////////////////
    always_ff @(posedge CLK_I or posedge RST_I)
    begin
        if (RST_I)
        begin
            state   <= S_IDLE;
            os_cnt  <= '0;
            bit_cnt <= '0;
        end
        else
        begin
            case (state)
                S_IDLE:
                    if (fall)
                    begin
                        state  <= S_START;
                        os_cnt <= '0;
                    end
                S_START:
                    if (en_rx)
                    begin
                        if (os_cnt == OS_HALF)
                        begin
                            os_cnt  <= '0;  // now at mid start bit
                            bit_cnt <= '0;
                            state   <= rxd_s2 ? S_IDLE : S_DATA;   // glitch, drop
                        end
                        else
                            os_cnt <= os_cnt + 1'b1;
                    end
                S_DATA, S_STOP:
                    if (en_rx)
                    begin
                        os_cnt <= sample ? '0 : os_cnt + 1'b1;
                        if (sample && state == S_STOP)
                            state <= S_IDLE;
                        else if (sample)
                        begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == 3'd7)
                                state <= S_STOP;
                        end
                    end
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    // new frame wins over a same-cycle read
    always_ff @(posedge CLK_I or posedge RST_I)
    begin
        if (RST_I)
            ctl.rx_ready <= 1'b0;
        else if (stop_ok)
            ctl.rx_ready <= 1'b1;
        else if (ctl.rx_clear)
            ctl.rx_ready <= 1'b0;
    end

    // data bits arrive lsb first
    always_ff @(posedge CLK_I)
    begin
        if (state == S_DATA && sample)
            sh <= {rxd_s2, sh[7:1]};
        if (stop_ok)
            ctl.rx_data <= sh;      // low stop bit keeps the old byte
    end

    a_ready_known: assert property (@(posedge CLK_I) disable iff (RST_I)
        !$isunknown(ctl.rx_ready));

endmodule

// ==== source/mini_uart.sv ====
/*
 * mini uart top level
 * bus slave registers, baud generator, transmitter and receiver
 */

module mini_uart #(
    parameter int DIV_W = 16
) (
    input  logic        CLK_I,
    input  logic        RST_I,
    input  logic [2:0]  ADD_I,    // word offset
    input  logic [31:0] DAT_I,
    output logic [31:0] DAT_O,
    input  logic        STB_I,
    input  logic        WE_I,
    output logic        ACK_O,
    input  logic        RxD,
    output logic        TxD
);

    uart_ctl_if #(.DIV_W(DIV_W)) ctl ();

    logic en_tx;                  // bit enable
    logic en_rx;                  // sample enable

    uart_regs #(.DIV_W(DIV_W)) u_regs (
        .CLK_I (CLK_I),
        .RST_I (RST_I),
        .adr   (ADD_I),
        .dat_w (DAT_I),
        .dat_r (DAT_O),
        .stb   (STB_I),
        .we    (WE_I),
        .ack   (ACK_O),
        .ctl   (ctl.regs)
    );

    uart_baud_gen #(.DIV_W(DIV_W)) u_baud (
        .CLK_I (CLK_I),
        .RST_I (RST_I),
        .ctl   (ctl.baud),
        .en_tx (en_tx),
        .en_rx (en_rx)
    );

    uart_tx u_tx (
        .CLK_I (CLK_I),
        .RST_I (RST_I),
        .ctl   (ctl.tx),
        .en_tx (en_tx),
        .txd   (TxD)
    );

    uart_rx u_rx (
        .CLK_I (CLK_I),
        .RST_I (RST_I),
        .ctl   (ctl.rx),
        .en_rx (en_rx),
        .rxd   (RxD)
    );

endmodule

// ==== verification/tb_mini_uart.sv ====
/*
 * mini uart testbench
 * replays a record trace of bus accesses and serial frames against the DUT
 */

module tb_mini_uart;

    localparam int DIV_W   = 16;
    localparam int MAX_REC = 64;

    logic        CLK_I;
    logic        RST_I;
    logic [2:0]  ADD_I;
    logic [31:0] DAT_I;
    logic [31:0] DAT_O;
    logic        STB_I;
    logic        WE_I;
    logic        ACK_O;
    logic        RxD;
    logic        TxD;

    logic [43:0] trace_mem [MAX_REC];   // op ascii, offset nibble, value
    int          n_rec;
    int          val_errs;
    int          proto_errs;
    int          cycles = 0;
    int          limit  = 0;            // 0 until the trace is scanned
    int          cur_divt;              // divisors as last written
    int          cur_divr;
    logic        rx_flag;               // expected rx-ready level

    mini_uart #(.DIV_W(DIV_W)) DUT (
        .CLK_I (CLK_I),
        .RST_I (RST_I),
        .ADD_I (ADD_I),
        .DAT_I (DAT_I),
        .DAT_O (DAT_O),
        .STB_I (STB_I),
        .WE_I  (WE_I),
        .ACK_O (ACK_O),
        .RxD   (RxD),
        .TxD   (TxD)
    );

    initial CLK_I = 1'b0;
    always #4 CLK_I = ~CLK_I;           // period 8

    always @(posedge CLK_I)
    begin
        cycles = cycles + 1;
        if (limit > 0 && cycles > limit)
        begin
            $display("timeout, trace not finished after %0d cycles", cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////
    task automatic protocol_error(input string msg);
        proto_errs++;
        $display("%s", msg);
    endtask

    // zero-wait slave, ack tracks strobe in every cycle
    always @(negedge CLK_I)
    begin
        if (!RST_I && ACK_O !== STB_I)
            protocol_error("ACK_O does not follow STB_I");
    end

    task automatic cmp_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp)
        begin
            val_errs++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic cmp_lsr(input string name, input uart_pkg::lsr_t exp,
                           input uart_pkg::lsr_t act);
        if (act !== exp)
        begin
            val_errs++;
            $display("[FAIL] %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic cmp_byte(input string name, input uart_pkg::byte_t exp,
                            input uart_pkg::byte_t act);
        if (act !== exp)
        begin
            val_errs++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    //////////////////////////////////////////////////
    // bus and serial drivers
    //////////////////////////////////////////////////
    task automatic tick(input int n);
        repeat (n) @(posedge CLK_I);
        #1;                             // back to the drive point
    endtask

    task automatic bus_access(input logic wr, input logic [2:0] off,
                              input logic [31:0] val, output logic [31:0] rd);
        ADD_I = off;
        DAT_I = val;
        WE_I  = wr;
        STB_I = 1'b1;
        #2;                             // mid cycle, mux settled
        rd = DAT_O;
        tick(1);                        // access takes effect at this edge
        STB_I = 1'b0;
        WE_I  = 1'b0;
    endtask

    // poll status until one bit is set, one cycle per read
    task automatic wait_status_bit(input int bit_pos, input int max_reads, input string what);
        logic [31:0] rd;
        int          n;
        n = 0;
        bus_access(1'b0, uart_pkg::off_lsr, '0, rd);
        while (rd[bit_pos] !== 1'b1 && n < max_reads)
        begin
            bus_access(1'b0, uart_pkg::off_lsr, '0, rd);
            n++;
        end
        if (rd[bit_pos] !== 1'b1)
            protocol_error(what);
    endtask

    task automatic send_frame(input int idx, input uart_pkg::byte_t b, input logic stop);
        int bitper;
        bitper = cur_divr * uart_pkg::rx_os;
        RxD = 1'b0;                     // start
        tick(bitper);
        for (int i = 0; i < 8; i++)
        begin
            RxD = b[i];
            tick(bitper);
        end
        RxD = stop;
        tick(bitper);
        RxD = 1'b1;
        tick(stop ? 2 : bitper);        // bad frame gets a full idle bit
        if (stop)
        begin
            rx_flag = 1'b1;
            wait_status_bit(uart_pkg::lsr_rx_ready_bit, bitper,
                            $sformatf("record %0d: rx-ready not set after the frame", idx));
        end
    endtask

    task automatic check_tx_frame(input int idx, input uart_pkg::byte_t exp);
        int              bitper;
        int              waited;
        uart_pkg::byte_t got;
        logic [31:0]     rd;
        string           name;
        bitper = cur_divt;
        name   = $sformatf("record %0d tx", idx);
        waited = 0;
        while (TxD === 1'b1 && waited < 20 * bitper)   // two frame times
        begin
            tick(1);
            waited++;
        end
        if (TxD !== 1'b0)
            protocol_error($sformatf("record %0d: no frame on TxD in two frame times", idx));
        else
        begin
            tick(bitper / 2);                           // mid start bit
            if (TxD !== 1'b0)
                protocol_error($sformatf("record %0d: start bit too short", idx));
            bus_access(1'b0, uart_pkg::off_lsr, '0, rd);    // one cycle
            // tx busy, only rx-ready may show
            cmp_lsr({name, " busy status"}, {5'b00000, rx_flag}, rd[5:0]);
            tick(bitper - 1);
            for (int i = 0; i < 8; i++)
            begin
                got[i] = TxD;                           // lsb first
                tick(bitper);
            end
            cmp_byte({name, " byte"}, exp, got);
            if (TxD !== 1'b1)
                protocol_error($sformatf("record %0d: stop bit on TxD is low", idx));
            wait_status_bit(uart_pkg::lsr_tx_ready_bit, bitper,
                            $sformatf("record %0d: tx-ready not back after the frame", idx));
        end
    endtask

    //////////////////////////////////////////////////
    // trace replay
    //////////////////////////////////////////////////
    task automatic run_record(input int r);
        logic [7:0]  op;
        logic [2:0]  off;
        logic [31:0] val;
        logic [31:0] rd;
        string       name;
        op   = trace_mem[r][43:36];
        off  = trace_mem[r][34:32];
        val  = trace_mem[r][31:0];
        name = $sformatf("record %0d read offset %0d", r, off);
        case (op)
            "W":
            begin
                bus_access(1'b1, off, val, rd);
                if (off == uart_pkg::off_divt)
                    cur_divt = val[DIV_W-1:0];
                if (off == uart_pkg::off_divr)
                    cur_divr = val[DIV_W-1:0];
            end
            "R":
            begin
                bus_access(1'b0, off, '0, rd);
                case (off)
                    uart_pkg::off_data:
                    begin
                        cmp_byte(name, val[7:0], rd[7:0]);
                        rx_flag = 1'b0;             // data read releases the byte
                    end
                    uart_pkg::off_lsr: cmp_lsr(name, val[5:0], rd[5:0]);
                    default:           cmp_word(name, val, rd);
                endcase
            end
            "T": check_tx_frame(r, val[7:0]);
            "X": send_frame(r, val[7:0], 1'b1);
            "B": send_frame(r, val[7:0], 1'b0);
            default: protocol_error($sformatf("record %0d: unknown op %h", r, op));
        endcase
    endtask

    // 20 bit periods per frame, 4 cycles per bus access
    function automatic int run_budget();
        int         total;
        int         dt;
        int         dr;
        logic [7:0] op;
        total = 100;
        dt    = uart_pkg::baud_snd_reset;
        dr    = uart_pkg::baud_rcv_reset;
        for (int r = 0; r < n_rec; r++)
        begin
            op = trace_mem[r][43:36];
            if (op == "W" && trace_mem[r][34:32] == uart_pkg::off_divt)
                dt = trace_mem[r][DIV_W-1:0];
            if (op == "W" && trace_mem[r][34:32] == uart_pkg::off_divr)
                dr = trace_mem[r][DIV_W-1:0];
            if (op == "T")
                total += 20 * dt;
            else if (op == "X" || op == "B")
                total += 20 * dr * uart_pkg::rx_os;
            else
                total += 4;
        end
        return total;
    endfunction

    initial
    begin
        RST_I = 1'b1;
        STB_I = 1'b0;
        WE_I  = 1'b0;
        ADD_I = '0;
        DAT_I = '0;
        RxD   = 1'b1;                   // line idle
        val_errs   = 0;
        proto_errs = 0;
        rx_flag    = 1'b0;
        cur_divt   = uart_pkg::baud_snd_reset;
        cur_divr   = uart_pkg::baud_rcv_reset;
        for (int i = 0; i < MAX_REC; i++)
            trace_mem[i] = {8'h00, 36'(i)};             // op 0 ends the trace
        $readmemh("verification/uart_trace.txt", trace_mem);
        n_rec = 0;
        while (n_rec < MAX_REC && trace_mem[n_rec][43:36] != 8'h00)
            n_rec++;
        limit = run_budget();
        repeat (2) @(posedge CLK_I);
        #1;
        RST_I = 1'b0;
        if (TxD !== 1'b1)
            protocol_error("TxD not high after reset");
        for (int r = 0; r < n_rec; r++)
            run_record(r);
        tick(2);
        $display("%0d records, %0d value errors, %0d protocol errors",
                 n_rec, val_errs, proto_errs);
        if (val_errs == 0 && proto_errs == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== verification/uart_trace.txt ====
// columns: op as ascii hex (57 W, 52 R, 54 T, 58 X, 42 B) _ offset _ value or byte
// W write, R read and expect, T expect on TxD, X send on RxD, B send with low stop bit
52_1_00000020   // reset status, tx ready only
52_2_000000a3   // rx divisor reset
52_3_00000a2c   // tx divisor reset
52_4_00000000   // unused offset
52_7_00000000
57_3_00000020   // tx 32 clocks per bit
57_2_00000002   // rx 2 x 16 clocks per bit
52_3_00000020
52_2_00000002
57_5_ffffffff   // ignored
52_5_00000000
57_0_000000a5
54_0_000000a5
52_1_00000020
58_0_0000003c
52_1_00000021
52_0_0000003c
52_1_00000020   // cleared by the data read
58_0_00000011
58_0_000000e7   // overwrites the unread byte
52_1_00000021
52_0_000000e7
58_0_00000055
42_0_0000000f   // bad stop, ready stays set
52_1_00000021
52_0_00000055
42_0_00000099   // bad stop, ready stays clear
52_1_00000020
52_0_00000055
57_3_00000030   // new bit period 48
57_2_00000003
52_3_00000030
57_0_000000c3
54_0_000000c3
58_0_00000096
52_1_00000021
52_0_00000096

// ==== sim.f ====
source/uart_pkg.sv
source/uart_ctl_if.sv
source/uart_regs.sv
source/uart_baud_gen.sv
source/uart_tx.sv
source/uart_rx.sv
source/mini_uart.sv
verification/tb_mini_uart.sv

// ==== Bender.yml ====
package:
  name: mini_uart

sources:
  - source/uart_pkg.sv
  - source/uart_ctl_if.sv
  - source/uart_regs.sv
  - source/uart_baud_gen.sv
  - source/uart_tx.sv
  - source/uart_rx.sv
  - source/mini_uart.sv
  - target: test
    files:
      - verification/tb_mini_uart.sv
